// File: sim.f
logic/vl53_pkg.sv
logic/spad_xfer_if.sv
logic/init_rom.sv
logic/init_sequencer.sv
logic/spad_map_capture.sv
logic/spad_byte_filter.sv
logic/spad_map_writer.sv
logic/vl53_init_top.sv
dv/tb_clk_gen.sv
dv/vl53_init_properties.sv
dv/tb_vl53_init.sv

// File: Makefile
TOP := tb_vl53_init

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@! grep -q "SOME TESTS FAILED" sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_vl53_init.sv
`timescale 1ns/100ps

module tb_vl53_init;
	import vl53_pkg::*;

	localparam int PROG_TIMEOUT = 5000; // cycles for one whole program
	localparam int WAIT_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 50;

	// standard-mode, stop-variable and tuning writes of the sensor init list
	localparam logic [15:0] TUNING [0:14] = '{
		16'h8800, 16'h8001, 16'hFF01, 16'h0000,
		16'h0001, 16'hFF00, 16'h8000,
		16'hFF01, 16'h0000, 16'hFF00, 16'h0900,
		16'h1000, 16'h1100, 16'h2401, 16'h25FF
	};

	logic       clk;
	logic       arst_n;
	logic       start;
	logic       comm_error;
	reg_data_t  spad_count;
	logic       spad_is_aperture;
	logic       cmd_start;
	bus_op_e    cmd_op;
	reg_addr_t  cmd_reg;
	reg_data_t  cmd_data;
	logic [3:0] cmd_len;
	logic       cmd_done = 1'b0;
	logic       rd_pop;
	logic       rd_valid = 1'b0;
	reg_data_t  rd_data = 8'h00;
	logic       wr_push;
	reg_data_t  wr_data;
	logic       wr_ack = 1'b0;
	reg_data_t  stop_variable;
	logic       done;

	// device model state
	reg_data_t  regs [0:255];
	int         cmd_wait = 0;
	int         rd_wait = 0;
	int         ack_wait = 0;
	reg_addr_t  rd_ptr = 8'h00;
	int         cmd_count = 0;
	int         done_count = 0;

	bus_op_e    log_op [$];
	reg_addr_t  log_reg [$];
	reg_data_t  log_data [$];
	logic [3:0] log_len [$];
	reg_data_t  log_burst [$];

	bus_op_e    exp_op [$];
	reg_addr_t  exp_reg [$];
	reg_data_t  exp_data [$];
	logic [3:0] exp_len [$];

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clk_gen u_clk (.clk);

	vl53_init_top u_dut (
		.clk, .arst_n, .start, .comm_error, .spad_count, .spad_is_aperture,
		.cmd_start, .cmd_op, .cmd_reg, .cmd_data, .cmd_len, .cmd_done,
		.rd_pop, .rd_valid, .rd_data,
		.wr_push, .wr_data, .wr_ack,
		.stop_variable, .done
	);

	//////////////////////////////
	// device model
	//////////////////////////////
	always @(posedge clk) begin
		cmd_done <= 1'b0;
		if (cmd_wait == 1)
			cmd_done <= 1'b1;
		if (cmd_wait != 0)
			cmd_wait <= cmd_wait - 1;
		if (cmd_start) begin
			log_op.push_back(cmd_op);
			log_reg.push_back(cmd_reg);
			log_data.push_back(cmd_data);
			log_len.push_back(cmd_len);
			cmd_count <= cmd_count + 1;
			cmd_wait  <= $urandom_range(8, 1);
		end
		if (done)
			done_count <= done_count + 1;
	end

	// read stream, served from the register array
	always @(posedge clk) begin
		rd_valid <= 1'b0;
		if (cmd_start && cmd_op == op_read)
			rd_ptr <= cmd_reg;
		if (rd_wait == 1) begin
			rd_valid <= 1'b1;
			rd_data  <= regs[rd_ptr];
			rd_ptr   <= rd_ptr + 8'd1; // burst reads walk up
		end
		if (rd_wait != 0)
			rd_wait <= rd_wait - 1;
		if (rd_pop)
			rd_wait <= $urandom_range(4, 1);
	end

	// burst-write FIFO
	always @(posedge clk) begin
		wr_ack <= 1'b0;
		if (ack_wait == 1)
			wr_ack <= 1'b1;
		if (ack_wait != 0)
			ack_wait <= ack_wait - 1;
		if (wr_push) begin
			log_burst.push_back(wr_data);
			ack_wait <= $urandom_range(5, 1);
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	task automatic check_byte(input string what, input reg_data_t exp, input reg_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected 0x%02h, actual 0x%02h", what, exp, act);
		end
	endtask

	task automatic check_op(input string what, input bus_op_e exp, input bus_op_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %s, actual %s (%0d)", what, exp.name(), act.name(),
				act);
		end
	endtask

	// keeps set SPADs from the first allowed one up to the count
	function automatic logic [SPAD_MAP_BITS-1:0] expected_spad_map(
		input logic [SPAD_MAP_BITS-1:0] raw,
		input reg_data_t                limit,
		input logic                     aperture
	);
		logic [SPAD_MAP_BITS-1:0] kept;
		int                       enabled;
		int                       first;
		kept    = '0;
		enabled = 0;
		first   = aperture ? APERTURE_FIRST_SPAD : 0;
		for (int n = first; n < SPAD_MAP_BITS; n++) begin
			if (raw[n] && enabled < int'(limit)) begin
				kept[n] = 1'b1;
				enabled++;
			end
		end
		return kept;
	endfunction

	task automatic clear_logs();
		log_op.delete();
		log_reg.delete();
		log_data.delete();
		log_len.delete();
		log_burst.delete();
	endtask

	task automatic preset_device(input logic aperture);
		for (int a = 0; a < 256; a++)
			regs[a] = 8'(a) ^ 8'h5A;
		regs[VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV] = 8'($urandom);
		regs[MSRC_CONFIG_CONTROL]             = 8'($urandom);
		regs[GPIO_HV_MUX_ACTIVE_HIGH]         = 8'($urandom);
		regs[STOP_VARIABLE_REG]               = 8'($urandom_range(255, 1));
		for (int k = 0; k < SPAD_MAP_BYTES; k++)
			regs[GLOBAL_CONFIG_SPAD_ENABLES_REF_0 + k] = 8'($urandom);
		spad_count       <= 8'($urandom_range(30, 1));
		spad_is_aperture <= aperture;
		clear_logs();
	endtask

	task automatic add_exp(input bus_op_e op, input reg_addr_t r, input reg_data_t d,
			input logic [3:0] len);
		exp_op.push_back(op);
		exp_reg.push_back(r);
		exp_data.push_back(d);
		exp_len.push_back(len);
	endtask

	task automatic add_rom_block(input int first, input int last);
		for (int i = first; i <= last; i++)
			add_exp(op_write, TUNING[i][15:8], TUNING[i][7:0], 4'd1);
	endtask

	task automatic build_expected();
		exp_op.delete();
		exp_reg.delete();
		exp_data.delete();
		exp_len.delete();
		add_exp(op_read, VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV, 8'h00, 4'd1);
		add_exp(op_write, VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV,
			regs[VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV] | 8'h01, 4'd1);
		add_rom_block(0, 3);
		add_exp(op_read, STOP_VARIABLE_REG, 8'h00, 4'd1);
		add_rom_block(4, 6);
		add_exp(op_read, MSRC_CONFIG_CONTROL, 8'h00, 4'd1);
		add_exp(op_write, MSRC_CONFIG_CONTROL, regs[MSRC_CONFIG_CONTROL] | 8'h12, 4'd1);
		add_exp(op_write, SYSTEM_SEQUENCE_CONFIG, 8'hFF, 4'd1);
		add_exp(op_read, GLOBAL_CONFIG_SPAD_ENABLES_REF_0, 8'h00, 4'd6);
		add_exp(op_write, PAGE_SELECT, 8'h01, 4'd1);
		add_exp(op_write, DYNAMIC_SPAD_REF_EN_START_OFFSET, 8'h00, 4'd1);
		add_exp(op_write, DYNAMIC_SPAD_NUM_REQUESTED_REF_SPAD, 8'h2C, 4'd1);
		add_exp(op_write, PAGE_SELECT, 8'h00, 4'd1);
		add_exp(op_write, GLOBAL_CONFIG_REF_EN_START_SELECT, 8'hB4, 4'd1);
		add_exp(op_write_multi, GLOBAL_CONFIG_SPAD_ENABLES_REF_0, 8'h00, 4'd6);
		add_rom_block(7, 14);
		add_exp(op_write, SYSTEM_INTERRUPT_CONFIG_GPIO, 8'h04, 4'd1);
		add_exp(op_read, GPIO_HV_MUX_ACTIVE_HIGH, 8'h00, 4'd1);
		add_exp(op_write, GPIO_HV_MUX_ACTIVE_HIGH, regs[GPIO_HV_MUX_ACTIVE_HIGH] & ~8'h10,
			4'd1);
		add_exp(op_write, SYSTEM_INTERRUPT_CLEAR, 8'h01, 4'd1);
	endtask

	task automatic check_program(input string name);
		int n;
		if (log_op.size() != exp_op.size()) begin
			errors++;
			$display("ERROR %s: %0d transactions issued where %0d were expected", name,
				log_op.size(), exp_op.size());
		end
		n = (log_op.size() < exp_op.size()) ? log_op.size() : exp_op.size();
		for (int i = 0; i < n; i++) begin
			check_op($sformatf("%s txn %0d op", name, i), exp_op[i], log_op[i]);
			check_byte($sformatf("%s txn %0d reg", name, i), exp_reg[i], log_reg[i]);
			check_byte($sformatf("%s txn %0d len", name, i), {4'h0, exp_len[i]},
				{4'h0, log_len[i]});
			if (exp_op[i] == op_write)
				check_byte($sformatf("%s txn %0d data", name, i), exp_data[i], log_data[i]);
		end
	endtask

	task automatic check_burst(input string name);
		logic [SPAD_MAP_BITS-1:0] raw;
		logic [SPAD_MAP_BITS-1:0] kept;
		for (int k = 0; k < SPAD_MAP_BYTES; k++)
			raw[8*k +: 8] = regs[GLOBAL_CONFIG_SPAD_ENABLES_REF_0 + k];
		kept = expected_spad_map(raw, spad_count, spad_is_aperture);
		if (log_burst.size() != SPAD_MAP_BYTES) begin
			errors++;
			$display("ERROR %s: %0d burst bytes pushed instead of %0d", name,
				log_burst.size(), SPAD_MAP_BYTES);
		end else begin
			for (int k = 0; k < SPAD_MAP_BYTES; k++)
				check_byte($sformatf("%s burst byte %0d", name, k), kept[8*k +: 8],
					log_burst[k]);
		end
	endtask

	//////////////////////////////
	// sequencing helpers
	//////////////////////////////
	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_program(input string name);
		int cycles;
		int done_before;
		done_before = done_count;
		pulse_start();
		cycles = 0;
		while (!done && cycles < PROG_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			errors++;
			$display("ERROR %s: done never pulsed within %0d cycles", name, PROG_TIMEOUT);
		end
		repeat (5) @(posedge clk); // let the last log entries settle
		check_byte($sformatf("%s done pulses", name), 8'd1, 8'(done_count - done_before));
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_full_program();
		int err_start;
		err_start = errors;
		preset_device(1'b0);
		build_expected();
		run_program("full_program");
		check_program("full_program");
		end_test("full_program", err_start);
	endtask

	task automatic test_stop_variable();
		int err_start;
		err_start = errors;
		preset_device(1'b0);
		run_program("stop_variable");
		check_byte("stop_variable value", regs[STOP_VARIABLE_REG], stop_variable);
		end_test("stop_variable", err_start);
	endtask

	task automatic test_spad_filter(input logic aperture);
		int    err_start;
		string name;
		err_start = errors;
		name      = aperture ? "spad_aperture" : "spad_no_aperture";
		preset_device(aperture);
		run_program(name);
		check_burst(name);
		if (aperture && log_burst.size() == SPAD_MAP_BYTES) begin
			check_byte({name, " spads 0-7"}, 8'h00, log_burst[0]);
			check_byte({name, " spads 8-11"}, 8'h00, log_burst[1] & 8'h0F);
		end
		end_test(name, err_start);
	endtask

	task automatic test_comm_error_abort();
		int err_start;
		int base;
		int cycles;
		bit quiet;
		err_start = errors;
		preset_device(1'b0);
		base = cmd_count;
		pulse_start();
		cycles = 0;
		// abort once the stop variable is in and the ROM block after it runs
		while (cmd_count < base + 9 && cycles < WAIT_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (cmd_count < base + 9) begin
			errors++;
			$display("ERROR comm_error_abort: program stalled before the abort point");
		end
		check_byte("comm_error_abort stop before abort", regs[STOP_VARIABLE_REG],
			stop_variable);
		comm_error <= 1'b1;
		@(posedge clk);
		comm_error <= 1'b0;
		@(posedge clk);
		check_byte("comm_error_abort stop after abort", 8'h00, stop_variable);
		quiet = 1'b1;
		for (int c = 0; c < QUIET_CYCLES; c++) begin
			@(posedge clk);
			if (cmd_start || done)
				quiet = 1'b0;
		end
		if (!quiet) begin
			errors++;
			$display("ERROR comm_error_abort: command or done seen after comm_error");
		end
		clear_logs();
		build_expected();
		run_program("comm_error_restart");
		check_program("comm_error_restart");
		check_burst("comm_error_restart");
		check_byte("comm_error_restart stop", regs[STOP_VARIABLE_REG], stop_variable);
		end_test("comm_error_abort", err_start);
	endtask

	initial begin
		arst_n           = 1'b1;
		start            = 1'b0;
		comm_error       = 1'b0;
		spad_count       = 8'h00;
		spad_is_aperture = 1'b0;
		void'($urandom(32'hf501db17));
		apply_reset();
		test_full_program();
		test_stop_variable();
		test_spad_filter(1'b0);
		test_spad_filter(1'b1);
		test_comm_error_abort();
		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: dv/vl53_init_properties.sv
`timescale 1ns/100ps

module vl53_init_properties (
	input logic                clk,
	input logic                arst_n,
	input logic                cmd_start,
	input vl53_pkg::bus_op_e   cmd_op,
	input vl53_pkg::reg_addr_t cmd_reg,
	input logic                cmd_done,
	input logic                rd_pop,
	input logic                wr_push,
	input logic                done
);

	logic cmd_open; // issued, cmd_done still to come

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cmd_open <= 1'b0;
		else if (cmd_start)
			cmd_open <= 1'b1;
		else if (cmd_done)
			cmd_open <= 1'b0;
	end

	a_cmd_start_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) cmd_start |=> !cmd_start
	) else $error("cmd_start high for more than one cycle");

	a_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) done |=> !done
	) else $error("done high for more than one cycle");

	// fields held while the engine works on them
	a_cmd_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		cmd_open && !cmd_start |-> $stable(cmd_reg) && $stable(cmd_op)
	) else $error("cmd_reg or cmd_op changed before cmd_done");

	a_quiet_in_reset: assert property (
		@(posedge clk) !arst_n |-> !(cmd_start || rd_pop || wr_push || done)
	) else $error("strobe high during reset");

endmodule

bind vl53_init_top vl53_init_properties u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.cmd_start (cmd_start),
	.cmd_op    (cmd_op),
	.cmd_reg   (cmd_reg),
	.cmd_done  (cmd_done),
	.rd_pop    (rd_pop),
	.wr_push   (wr_push),
	.done      (done)
);

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #10 clk = ~clk; // 20 ns period

endmodule

// File: logic/vl53_init_top.sv
`timescale 1ns/100ps

module vl53_init_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                comm_error,
	input  vl53_pkg::reg_data_t spad_count,
	input  logic                spad_is_aperture,
	output logic                cmd_start,
	output vl53_pkg::bus_op_e   cmd_op,
	output vl53_pkg::reg_addr_t cmd_reg,
	output vl53_pkg::reg_data_t cmd_data,
	output logic [3:0]          cmd_len,
	input  logic                cmd_done,
	output logic                rd_pop,
	input  logic                rd_valid,
	input  vl53_pkg::reg_data_t rd_data,
	output logic                wr_push,
	output vl53_pkg::reg_data_t wr_data,
	input  logic                wr_ack,
	output vl53_pkg::reg_data_t stop_variable,
	output logic                done
);
	import vl53_pkg::*;

	logic [3:0]  rom_addr;
	logic [15:0] rom_entry;
	spad_map_u   raw_map;
	spad_map_u   filt_map;
	reg_data_t   en_chain [0:SPAD_MAP_BYTES-1]; // SPADs kept before each byte

	spad_xfer_if xfer ();

	init_sequencer u_seq (
		.clk, .arst_n, .start, .comm_error,
		.rom_addr, .rom_entry,
		.xfer          (xfer.seq),
		.cmd_start, .cmd_op, .cmd_reg, .cmd_data, .cmd_len, .cmd_done,
		.rd_pop, .rd_valid, .rd_data,
		.stop_variable, .done
	);

	init_rom u_rom (.clk, .rom_addr, .rom_entry);

	spad_map_capture u_capture (
		.clk, .arst_n, .rd_valid, .rd_data,
		.xfer    (xfer.capture),
		.raw_map (raw_map)
	);

	//////////////////////////////
	// filter chain, byte 0 first
	//////////////////////////////
	assign en_chain[0] = '0;

	for (genvar i = 0; i < SPAD_MAP_BYTES; i++) begin : g_filter
		if (i < SPAD_MAP_BYTES - 1) begin : g_mid
			spad_byte_filter #(.BYTE_IDX(i)) u_filter (
				.raw_byte         (raw_map.bits[8*i +: 8]),
				.spad_count       (spad_count),
				.spad_is_aperture (spad_is_aperture),
				.enabled_in       (en_chain[i]),
				.filt_byte        (filt_map.bits[8*i +: 8]),
				.enabled_out      (en_chain[i+1])
			);
		end else begin : g_last
			spad_byte_filter #(.BYTE_IDX(i)) u_filter (
				.raw_byte         (raw_map.bits[8*i +: 8]),
				.spad_count       (spad_count),
				.spad_is_aperture (spad_is_aperture),
				.enabled_in       (en_chain[i]),
				.filt_byte        (filt_map.bits[8*i +: 8]),
				.enabled_out      () // total not needed
			);
		end
	end

	spad_map_writer u_writer (
		.clk, .arst_n,
		.filt_map (filt_map),
		.xfer     (xfer.writer),
		.wr_push, .wr_data, .wr_ack
	);

endmodule

// File: logic/spad_map_writer.sv
`timescale 1ns/100ps

module spad_map_writer (
	input  logic                clk,
	input  logic                arst_n,
	input  vl53_pkg::spad_map_u filt_map,
	spad_xfer_if.writer         xfer,
	output logic                wr_push,
	output vl53_pkg::reg_data_t wr_data,
	input  logic                wr_ack
);
	import vl53_pkg::*;

	logic       busy;
	logic [2:0] idx; // byte being pushed

	// map is stable for the whole burst
	assign wr_data = filt_map.bytes[idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy           <= 1'b0;
			idx            <= '0;
			wr_push        <= 1'b0;
			xfer.send_done <= 1'b0;
		end else begin
			wr_push        <= 1'b0;
			xfer.send_done <= 1'b0;
			if (!busy) begin
				if (xfer.send_req) begin
					busy    <= 1'b1;
					idx     <= '0;
					wr_push <= 1'b1;
				end
			end else if (wr_ack) begin
				if (idx == 3'(SPAD_MAP_BYTES - 1)) begin
					busy           <= 1'b0;
					xfer.send_done <= 1'b1;
				end else begin
					idx     <= idx + 3'd1;
					wr_push <= 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/spad_byte_filter.sv
`timescale 1ns/100ps

module spad_byte_filter #(
	parameter int BYTE_IDX = 0
) (
	input  vl53_pkg::reg_data_t raw_byte,
	input  vl53_pkg::reg_data_t spad_count,
	input  logic                spad_is_aperture,
	input  vl53_pkg::reg_data_t enabled_in,  // SPADs kept in lower bytes
	output vl53_pkg::reg_data_t filt_byte,
	output vl53_pkg::reg_data_t enabled_out
);
	import vl53_pkg::*;

	int        first_spad;
	reg_data_t count;

	always_comb begin
		first_spad = spad_is_aperture ? APERTURE_FIRST_SPAD : 0;
		count      = enabled_in;
		for (int b = 0; b < 8; b++) begin
			if ((BYTE_IDX * 8 + b) < first_spad || count == spad_count) begin
				filt_byte[b] = 1'b0; // outside the window or quota reached
			end else begin
				filt_byte[b] = raw_byte[b];
				if (raw_byte[b])
					count = count + 8'd1;
			end
		end
		enabled_out = count;
	end

endmodule

// File: logic/spad_map_capture.sv
`timescale 1ns/100ps

module spad_map_capture (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                rd_valid,
	input  vl53_pkg::reg_data_t rd_data,
	spad_xfer_if.capture        xfer,
	output vl53_pkg::spad_map_u raw_map
);
	import vl53_pkg::*;

	logic [2:0] count; // next byte slot
	logic       store;

	assign store         = xfer.cap_en && rd_valid && !xfer.map_full;
	assign xfer.map_full = (count == 3'(SPAD_MAP_BYTES));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count           <= '0;
			xfer.cap_stored <= 1'b0;
		end else begin
			xfer.cap_stored <= store;
			if (!xfer.cap_en)
				count <= '0; // ready for the next program run
			else if (store)
				count <= count + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (store)
			raw_map.bytes[count] <= rd_data;
	end

endmodule

// File: logic/init_sequencer.sv
`timescale 1ns/100ps

module init_sequencer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                comm_error,
	output logic [3:0]          rom_addr,
	input  logic [15:0]         rom_entry,
	spad_xfer_if.seq            xfer,
	output logic                cmd_start,
	output vl53_pkg::bus_op_e   cmd_op,
	output vl53_pkg::reg_addr_t cmd_reg,
	output vl53_pkg::reg_data_t cmd_data,
	output logic [3:0]          cmd_len,
	input  logic                cmd_done,
	output logic                rd_pop,
	input  logic                rd_valid,
	input  vl53_pkg::reg_data_t rd_data,
	output vl53_pkg::reg_data_t stop_variable,
	output logic                done
);
	import vl53_pkg::*;

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_ISSUE     = 3'd1;
	localparam logic [2:0] S_WAIT_CMD  = 3'd2;
	localparam logic [2:0] S_WAIT_RD   = 3'd3;
	localparam logic [2:0] S_WAIT_CAP  = 3'd4;
	localparam logic [2:0] S_WAIT_SEND = 3'd5;

	// program steps, run in this order
	localparam logic [4:0] ST_VHV_RD    = 5'd0;
	localparam logic [4:0] ST_VHV_WR    = 5'd1;
	localparam logic [4:0] ST_ROM_STD   = 5'd2;
	localparam logic [4:0] ST_STOP_RD   = 5'd3;
	localparam logic [4:0] ST_ROM_STOP  = 5'd4;
	localparam logic [4:0] ST_MSRC_RD   = 5'd5;
	localparam logic [4:0] ST_MSRC_WR   = 5'd6;
	localparam logic [4:0] ST_SEQ_CFG   = 5'd7;
	localparam logic [4:0] ST_SPAD_RD   = 5'd8;
	localparam logic [4:0] ST_PAGE_1    = 5'd9;
	localparam logic [4:0] ST_START_OFS = 5'd10;
	localparam logic [4:0] ST_NUM_REQ   = 5'd11;
	localparam logic [4:0] ST_PAGE_0    = 5'd12;
	localparam logic [4:0] ST_START_SEL = 5'd13;
	localparam logic [4:0] ST_SEND      = 5'd14;
	localparam logic [4:0] ST_SPAD_WR   = 5'd15;
	localparam logic [4:0] ST_ROM_TUNE  = 5'd16;
	localparam logic [4:0] ST_GPIO_CFG  = 5'd17;
	localparam logic [4:0] ST_MUX_RD    = 5'd18;
	localparam logic [4:0] ST_MUX_WR    = 5'd19;
	localparam logic [4:0] ST_INT_CLR   = 5'd20;

	logic [2:0] state;
	logic [4:0] step;
	logic       rom_more;  // current ROM block has entries left
	reg_data_t  rd_byte;   // last byte read, for read-modify-write

	bus_op_e    d_op;
	reg_addr_t  d_reg;
	reg_data_t  d_data;
	logic [3:0] d_len;
	logic       d_rom;
	logic [3:0] d_rom_last;

	//////////////////////////////
	// step decode
	//////////////////////////////
	always_comb begin
		d_op       = op_write;
		d_reg      = PAGE_SELECT;
		d_data     = 8'h00;
		d_len      = 4'd1;
		d_rom      = 1'b0;
		d_rom_last = 4'(ROM_LAST);
		case (step)
			ST_VHV_RD: begin
				d_op  = op_read;
				d_reg = VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV;
			end
			ST_VHV_WR: begin
				d_reg  = VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV;
				d_data = rd_byte | 8'h01; // 2v8 io
			end
			ST_ROM_STD, ST_ROM_STOP, ST_ROM_TUNE: begin
				d_reg  = rom_entry[15:8];
				d_data = rom_entry[7:0];
				d_rom  = 1'b1;
				if (step == ST_ROM_STD)
					d_rom_last = 4'(ROM_STD_MODE_LAST);
				else if (step == ST_ROM_STOP)
					d_rom_last = 4'(ROM_STOP_LAST);
			end
			ST_STOP_RD: begin
				d_op  = op_read;
				d_reg = STOP_VARIABLE_REG;
			end
			ST_MSRC_RD: begin
				d_op  = op_read;
				d_reg = MSRC_CONFIG_CONTROL;
			end
			ST_MSRC_WR: begin
				d_reg  = MSRC_CONFIG_CONTROL;
				d_data = rd_byte | 8'h12; // no msrc / pre-range rate checks
			end
			ST_SEQ_CFG: begin
				d_reg  = SYSTEM_SEQUENCE_CONFIG;
				d_data = 8'hFF;
			end
			ST_SPAD_RD: begin
				d_op  = op_read;
				d_reg = GLOBAL_CONFIG_SPAD_ENABLES_REF_0;
				d_len = 4'(SPAD_MAP_BYTES);
			end
			ST_PAGE_1:    d_data = 8'h01;
			ST_START_OFS: d_reg  = DYNAMIC_SPAD_REF_EN_START_OFFSET;
			ST_NUM_REQ: begin
				d_reg  = DYNAMIC_SPAD_NUM_REQUESTED_REF_SPAD;
				d_data = 8'h2C;
			end
			ST_START_SEL: begin
				d_reg  = GLOBAL_CONFIG_REF_EN_START_SELECT;
				d_data = 8'hB4;
			end
			ST_SPAD_WR: begin
				d_op  = op_write_multi;
				d_reg = GLOBAL_CONFIG_SPAD_ENABLES_REF_0;
				d_len = 4'(SPAD_MAP_BYTES);
			end
			ST_GPIO_CFG: begin
				d_reg  = SYSTEM_INTERRUPT_CONFIG_GPIO;
				d_data = 8'h04; // new sample ready
			end
			ST_MUX_RD: begin
				d_op  = op_read;
				d_reg = GPIO_HV_MUX_ACTIVE_HIGH;
			end
			ST_MUX_WR: begin
				d_reg  = GPIO_HV_MUX_ACTIVE_HIGH;
				d_data = rd_byte & ~8'h10; // active low irq
			end
			ST_INT_CLR: begin
				d_reg  = SYSTEM_INTERRUPT_CLEAR;
				d_data = 8'h01;
			end
			default: ; // page 0 and the send step keep the defaults
		endcase
	end

	//////////////////////////////
	// program FSM
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= S_IDLE;
			step          <= ST_VHV_RD;
			rom_addr      <= '0;
			rom_more      <= 1'b0;
			cmd_start     <= 1'b0;
			rd_pop        <= 1'b0;
			done          <= 1'b0;
			stop_variable <= '0;
			xfer.cap_en   <= 1'b0;
			xfer.send_req <= 1'b0;
		end else begin
			cmd_start     <= 1'b0;
			rd_pop        <= 1'b0;
			done          <= 1'b0;
			xfer.send_req <= 1'b0;
			if (comm_error) begin
				state         <= S_IDLE;
				stop_variable <= '0;
				xfer.cap_en   <= 1'b0;
			end else begin
				case (state)
					S_IDLE: begin
						step     <= ST_VHV_RD;
						rom_addr <= '0;
						if (start)
							state <= S_ISSUE;
					end
					S_ISSUE: begin
						if (step == ST_SEND) begin
							xfer.send_req <= 1'b1;
							state         <= S_WAIT_SEND;
						end else begin
							cmd_start <= 1'b1;
							state     <= S_WAIT_CMD;
							rom_more  <= d_rom && (rom_addr != d_rom_last);
							if (d_rom)
								rom_addr <= rom_addr + 4'd1; // entry ready before cmd_done
							if (step == ST_SPAD_RD)
								xfer.cap_en <= 1'b1;
						end
					end
					S_WAIT_CMD: if (cmd_done) begin
						if (cmd_op == op_read) begin
							rd_pop <= 1'b1;
							state  <= xfer.cap_en ? S_WAIT_CAP : S_WAIT_RD;
						end else if (step == ST_INT_CLR) begin
							done  <= 1'b1;
							state <= S_IDLE;
						end else begin
							if (!rom_more)
								step <= step + 5'd1;
							state <= S_ISSUE;
						end
					end
					S_WAIT_RD: if (rd_valid) begin
						if (step == ST_STOP_RD)
							stop_variable <= rd_data;
						step  <= step + 5'd1;
						state <= S_ISSUE;
					end
					S_WAIT_CAP: if (xfer.cap_stored) begin
						if (xfer.map_full) begin
							xfer.cap_en <= 1'b0;
							step        <= step + 5'd1;
							state       <= S_ISSUE;
						end else begin
							rd_pop <= 1'b1; // next map byte
						end
					end
					S_WAIT_SEND: if (xfer.send_done) begin
						step  <= step + 5'd1;
						state <= S_ISSUE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// command fields held from cmd_start until cmd_done
	always_ff @(posedge clk) begin
		if (state == S_ISSUE && step != ST_SEND) begin
			cmd_op   <= d_op;
			cmd_reg  <= d_reg;
			cmd_data <= d_data;
			cmd_len  <= d_len;
		end
		if (rd_valid)
			rd_byte <= rd_data;
	end

endmodule

// File: logic/init_rom.sv
`timescale 1ns/100ps

module init_rom (
	input  logic        clk,
	input  logic [3:0]  rom_addr,
	output logic [15:0] rom_entry // {register, value}
);

	always_ff @(posedge clk) begin
		case (rom_addr)
			// i2c standard mode
			4'd0:  rom_entry <= 16'h8800;
			4'd1:  rom_entry <= 16'h8001;
			4'd2:  rom_entry <= 16'hFF01;
			4'd3:  rom_entry <= 16'h0000;
			// after the stop variable read
			4'd4:  rom_entry <= 16'h0001;
			4'd5:  rom_entry <= 16'hFF00;
			4'd6:  rom_entry <= 16'h8000;
			// default tuning, first part
			4'd7:  rom_entry <= 16'hFF01;
			4'd8:  rom_entry <= 16'h0000;
			4'd9:  rom_entry <= 16'hFF00;
			4'd10: rom_entry <= 16'h0900;
			4'd11: rom_entry <= 16'h1000;
			4'd12: rom_entry <= 16'h1100;
			4'd13: rom_entry <= 16'h2401;
			4'd14: rom_entry <= 16'h25FF;
			default: rom_entry <= 16'h0000;
		endcase
	end

endmodule

// File: logic/spad_xfer_if.sv
`timescale 1ns/100ps

interface spad_xfer_if;

	logic cap_en;     // held for the whole map read
	logic cap_stored; // one pulse per byte taken
	logic map_full;   // all six bytes in
	logic send_req;
	logic send_done;

	modport seq (
		output cap_en,
		output send_req,
		input  cap_stored,
		input  map_full,
		input  send_done
	);

	modport capture (input cap_en, output cap_stored, output map_full);

	modport writer (input send_req, output send_done);

endinterface

// File: logic/vl53_pkg.sv
package vl53_pkg;

	//////////////////////////////
	// bus types
	//////////////////////////////
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// same codes as the engine's function select
	typedef enum logic [1:0] {
		op_read        = 2'd1,
		op_write       = 2'd2,
		op_write_multi = 2'd3
	} bus_op_e;

	//////////////////////////////
	// reference SPAD map
	//////////////////////////////
	localparam int SPAD_MAP_BYTES      = 6;
	localparam int SPAD_MAP_BITS       = 48;
	localparam int APERTURE_FIRST_SPAD = 12; // aperture parts skip the first 12

	typedef union packed {
		logic [SPAD_MAP_BITS-1:0]       bits;  // one bit per SPAD
		reg_data_t [SPAD_MAP_BYTES-1:0] bytes; // as read over the bus
	} spad_map_u;

	//////////////////////////////
	// sensor registers
	//////////////////////////////
	localparam reg_addr_t VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV     = 8'h89;
	localparam reg_addr_t MSRC_CONFIG_CONTROL                 = 8'h60;
	localparam reg_addr_t SYSTEM_SEQUENCE_CONFIG              = 8'h01;
	localparam reg_addr_t GLOBAL_CONFIG_SPAD_ENABLES_REF_0    = 8'hB0;
	localparam reg_addr_t DYNAMIC_SPAD_REF_EN_START_OFFSET    = 8'h4F;
	localparam reg_addr_t DYNAMIC_SPAD_NUM_REQUESTED_REF_SPAD = 8'h4E;
	localparam reg_addr_t GLOBAL_CONFIG_REF_EN_START_SELECT   = 8'hB6;
	localparam reg_addr_t SYSTEM_INTERRUPT_CONFIG_GPIO        = 8'h0A;
	localparam reg_addr_t GPIO_HV_MUX_ACTIVE_HIGH             = 8'h84;
	localparam reg_addr_t SYSTEM_INTERRUPT_CLEAR              = 8'h0B;
	localparam reg_addr_t STOP_VARIABLE_REG                   = 8'h91;
	localparam reg_addr_t PAGE_SELECT                         = 8'hFF;

	// tuning ROM block ends
	localparam int ROM_STD_MODE_LAST = 3;
	localparam int ROM_STOP_LAST     = 6;
	localparam int ROM_LAST          = 14;

endpackage
